//--- project.f
src/mm_cfg_pkg.sv
src/mm_data_pkg.sv
src/mm_job_ctrl.sv
src/mm_addr_gen.sv
src/mm_mac_array.sv
src/mm_post_proc.sv
src/mm_top.sv
tb/mm_tb.sv

//--- run.sh
#!/bin/sh
# builds the matrix-vector engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module mm_tb \
   --Mdir obj_dir -o mm_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mm_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src/mm_addr_gen.sv
`timescale 1ns/1ps

module mm_addr_gen (
   input  logic                                clk,
   input  logic                                rstn,
   input  mm_cfg_pkg::mm_job_t                 cfg,
   input  mm_cfg_pkg::mm_step_t                step,
   input  logic [mm_cfg_pkg::CNT_W-1:0]        ci_idx,
   input  logic [mm_cfg_pkg::CNT_W-1:0]        co_idx,
   input  logic [mm_cfg_pkg::NODE_W-1:0]       node_idx,
   output logic [mm_cfg_pkg::IN_ADDR_W-1:0]    input_addr,
   output logic                                input_addr_valid,
   output logic [mm_cfg_pkg::W_ADDR_W-1:0]     weight_addr,
   output logic                                weight_addr_valid,
   output logic [mm_cfg_pkg::BIAS_ADDR_W-1:0]  bias_addr,
   output logic                                bias_addr_valid,
   output mm_cfg_pkg::mm_step_t                step_out
);
   import mm_cfg_pkg::*;

   logic [IN_ADDR_W-1:0] in_base;
   logic [IN_ADDR_W-1:0] in_base_q;
   logic [W_ADDR_W-1:0]  w_base;
   logic [W_ADDR_W-1:0]  w_base_q;
   logic                 co_end;

   assign co_end = (co_idx == cfg.co_count - CNT_W'(1));

   // running bases replace node*ci_count and co*ci_count
   assign in_base = (node_idx == '0) ? cfg.input_start : in_base_q;
   assign w_base  = (co_idx == '0) ? cfg.weight_start : w_base_q;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         in_base_q <= '0;
         w_base_q  <= '0;
      end else if (step.valid && step.ci_last) begin
         w_base_q <= w_base + W_ADDR_W'(cfg.ci_count);
         if (co_end) begin
            in_base_q <= in_base + IN_ADDR_W'(cfg.ci_count);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // registered read requests
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         input_addr_valid  <= 1'b0;
         weight_addr_valid <= 1'b0;
         bias_addr_valid   <= 1'b0;
         step_out          <= '0;
      end else begin
         input_addr_valid  <= step.valid;
         weight_addr_valid <= step.valid;
         // one bias word per (node, co) group
         bias_addr_valid   <= step.valid & step.ci_last & cfg.bias_en;
         step_out          <= step;
      end
   end

   always_ff @(posedge clk) begin
      input_addr  <= in_base + IN_ADDR_W'(ci_idx);
      weight_addr <= w_base + W_ADDR_W'(ci_idx);
      bias_addr   <= cfg.bias_start + BIAS_ADDR_W'(co_idx);
   end

endmodule

//--- src/mm_cfg_pkg.sv
package mm_cfg_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // address and counter widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int IN_ADDR_W   = 11;
   localparam int W_ADDR_W    = 13;
   localparam int BIAS_ADDR_W = 9;
   localparam int OUT_ADDR_W  = 11;

   // ci and co counts
   localparam int CNT_W  = 8;
   localparam int NODE_W = 16;

   // last-ci address cycle to output_data_valid
   localparam int MM_PIPE_LAT = 4;

   ////////////////////////////////////////////////////////////////////////////
   // job description and per-chunk step tag
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [W_ADDR_W-1:0]    weight_start;
      logic [IN_ADDR_W-1:0]   input_start;
      logic [BIAS_ADDR_W-1:0] bias_start;
      logic [OUT_ADDR_W-1:0]  output_start;
      logic [CNT_W-1:0]       ci_count;
      logic [CNT_W-1:0]       co_count;
      logic [NODE_W-1:0]      node_count;
      logic                   bias_en;
      logic                   relu_en;
   } mm_job_t;

   // one issued input/weight chunk
   typedef struct packed {
      logic valid;
      logic ci_first;
      logic ci_last;
      // final chunk of the whole job
      logic job_last;
   } mm_step_t;

endpackage

//--- src/mm_data_pkg.sv
package mm_data_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // lane geometry
   ////////////////////////////////////////////////////////////////////////////

   localparam int LANES  = 4;
   localparam int DATA_W = 16;
   // products and sums wrap at this width
   localparam int ACC_W  = 32;

   ////////////////////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////////////////////

   // one input feature chunk
   typedef logic [LANES-1:0][DATA_W-1:0] lane_vec_t;

   // row j holds the weights of output lane j
   typedef logic [LANES-1:0][LANES-1:0][DATA_W-1:0] weight_tile_t;

   // accumulator, bias and output words
   typedef logic [LANES-1:0][ACC_W-1:0] acc_vec_t;

endpackage

//--- src/mm_job_ctrl.sv
`timescale 1ns/1ps

module mm_job_ctrl (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            start_valid,
   input  mm_cfg_pkg::mm_job_t             job,
   output mm_cfg_pkg::mm_job_t             cfg,
   output mm_cfg_pkg::mm_step_t            step,
   output logic [mm_cfg_pkg::CNT_W-1:0]    ci_idx,
   output logic [mm_cfg_pkg::CNT_W-1:0]    co_idx,
   output logic [mm_cfg_pkg::NODE_W-1:0]   node_idx,
   input  logic                            job_finished,
   output logic                            done
);
   import mm_cfg_pkg::*;

   mm_job_t           cfg_q;
   logic              busy;
   logic              issuing;
   logic              launch;
   logic              ci_end;
   logic              co_end;
   logic              node_end;
   logic [CNT_W-1:0]  ci_q;
   logic [CNT_W-1:0]  co_q;
   logic [NODE_W-1:0] node_q;

   // a start while busy is dropped
   assign launch = start_valid & ~busy;

   // first step issues in the start cycle itself
   assign cfg = launch ? job : cfg_q;

   assign ci_end   = (ci_q == cfg.ci_count - CNT_W'(1));
   assign co_end   = (co_q == cfg.co_count - CNT_W'(1));
   assign node_end = (node_q == cfg.node_count - NODE_W'(1));

   assign step.valid    = launch | issuing;
   assign step.ci_first = (ci_q == '0);
   assign step.ci_last  = ci_end;
   assign step.job_last = ci_end & co_end & node_end;

   assign ci_idx   = ci_q;
   assign co_idx   = co_q;
   assign node_idx = node_q;

   ////////////////////////////////////////////////////////////////////////////
   // loop counters, ci innermost then co then node
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ci_q    <= '0;
         co_q    <= '0;
         node_q  <= '0;
         issuing <= 1'b0;
      end else if (step.valid) begin
         issuing <= ~step.job_last;
         if (ci_end) begin
            ci_q <= '0;
            if (co_end) begin
               co_q   <= '0;
               node_q <= node_end ? '0 : node_q + NODE_W'(1);
            end else begin
               co_q <= co_q + CNT_W'(1);
            end
         end else begin
            ci_q <= ci_q + CNT_W'(1);
         end
      end
   end

   // busy until the last output leaves post processing
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         cfg_q <= '0;
         busy  <= 1'b0;
         done  <= 1'b0;
      end else begin
         done <= busy & job_finished;
         if (launch) begin
            cfg_q <= job;
            busy  <= 1'b1;
         end else if (job_finished) begin
            busy <= 1'b0;
         end
      end
   end

endmodule

//--- src/mm_mac_array.sv
`timescale 1ns/1ps

module mm_mac_array (
   input  logic                        clk,
   input  logic                        rstn,
   input  mm_data_pkg::lane_vec_t      input_data,
   input  logic                        input_data_valid,
   input  mm_data_pkg::weight_tile_t   weight_data,
   input  logic                        weight_data_valid,
   input  mm_cfg_pkg::mm_step_t        step_in,
   output mm_data_pkg::acc_vec_t       acc,
   output logic                        acc_valid,
   output logic                        acc_last
);
   import mm_cfg_pkg::*;
   import mm_data_pkg::*;

   mm_step_t     step_d1;
   mm_step_t     step_d2;
   lane_vec_t    x_g;
   weight_tile_t w_g;
   acc_vec_t     lane_sum;
   acc_vec_t     prod_q;

   // missing read data counts as zero
   assign x_g = input_data_valid ? input_data : '0;
   assign w_g = weight_data_valid ? weight_data : '0;

   ////////////////////////////////////////////////////////////////////////////
   // stage 1: tile times chunk, per output lane
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      logic signed [2*DATA_W-1:0] prod;
      for (int j = 0; j < LANES; j++) begin
         lane_sum[j] = '0;
         for (int k = 0; k < LANES; k++) begin
            prod        = $signed(w_g[j][k]) * $signed(x_g[k]);
            lane_sum[j] = lane_sum[j] + ACC_W'(prod);
         end
      end
   end

   always_ff @(posedge clk) begin
      prod_q <= lane_sum;
   end

   ////////////////////////////////////////////////////////////////////////////
   // stage 2: accumulate over ci
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (step_d2.valid) begin
         for (int j = 0; j < LANES; j++) begin
            acc[j] <= step_d2.ci_first ? prod_q[j] : acc[j] + prod_q[j];
         end
      end
   end

   // tag rides along with the data, first hop covers memory latency
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         step_d1   <= '0;
         step_d2   <= '0;
         acc_valid <= 1'b0;
         acc_last  <= 1'b0;
      end else begin
         step_d1   <= step_in;
         step_d2   <= step_d1;
         acc_valid <= step_d2.valid & step_d2.ci_last;
         acc_last  <= step_d2.valid & step_d2.job_last;
      end
   end

endmodule

//--- src/mm_post_proc.sv
`timescale 1ns/1ps

module mm_post_proc (
   input  logic                               clk,
   input  logic                               rstn,
   input  mm_cfg_pkg::mm_job_t                cfg,
   input  mm_data_pkg::acc_vec_t              bias_data,
   input  logic                               bias_data_valid,
   input  mm_data_pkg::acc_vec_t              acc,
   input  logic                               acc_valid,
   input  logic                               acc_last,
   output logic [mm_cfg_pkg::OUT_ADDR_W-1:0]  output_addr,
   output mm_data_pkg::acc_vec_t              output_data,
   output logic                               output_data_valid,
   output logic                               job_finished
);
   import mm_cfg_pkg::*;
   import mm_data_pkg::*;

   acc_vec_t bias_d1;
   acc_vec_t bias_d2;
   acc_vec_t biased;
   acc_vec_t result;
   logic     first_out;

   // bias word arrives two cycles before its accumulator result
   always_ff @(posedge clk) begin
      bias_d1 <= bias_data_valid ? bias_data : '0;
      bias_d2 <= bias_d1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // bias add and relu
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int j = 0; j < LANES; j++) begin
         biased[j] = acc[j] + (cfg.bias_en ? bias_d2[j] : '0);
         // clamp negative lanes
         result[j] = (cfg.relu_en && biased[j][ACC_W-1]) ? '0 : biased[j];
      end
   end

   always_ff @(posedge clk) begin
      if (acc_valid) begin
         output_data <= result;
      end
   end

   // sequential output addresses from output_start
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         output_addr       <= '0;
         output_data_valid <= 1'b0;
         job_finished      <= 1'b0;
         first_out         <= 1'b1;
      end else begin
         output_data_valid <= acc_valid;
         job_finished      <= acc_valid & acc_last;
         if (acc_valid) begin
            output_addr <= first_out ? cfg.output_start : output_addr + OUT_ADDR_W'(1);
            // rearm for the next job
            first_out   <= acc_last;
         end
      end
   end

endmodule

//--- src/mm_top.sv
`timescale 1ns/1ps

module mm_top (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                start_valid,
   input  mm_cfg_pkg::mm_job_t                 job,
   output logic [mm_cfg_pkg::IN_ADDR_W-1:0]    input_addr,
   output logic                                input_addr_valid,
   input  mm_data_pkg::lane_vec_t              input_data,
   input  logic                                input_data_valid,
   output logic [mm_cfg_pkg::W_ADDR_W-1:0]     weight_addr,
   output logic                                weight_addr_valid,
   input  mm_data_pkg::weight_tile_t           weight_data,
   input  logic                                weight_data_valid,
   output logic [mm_cfg_pkg::BIAS_ADDR_W-1:0]  bias_addr,
   output logic                                bias_addr_valid,
   input  mm_data_pkg::acc_vec_t               bias_data,
   input  logic                                bias_data_valid,
   output logic [mm_cfg_pkg::OUT_ADDR_W-1:0]   output_addr,
   output mm_data_pkg::acc_vec_t               output_data,
   output logic                                output_data_valid,
   output logic                                done
);
   import mm_cfg_pkg::*;
   import mm_data_pkg::*;

   mm_job_t           cfg;
   mm_step_t          step;
   mm_step_t          step_ag;
   logic [CNT_W-1:0]  ci_idx;
   logic [CNT_W-1:0]  co_idx;
   logic [NODE_W-1:0] node_idx;
   acc_vec_t          acc;
   logic              acc_valid;
   logic              acc_last;
   logic              job_finished;

   mm_job_ctrl u_job_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .start_valid  (start_valid),
      .job          (job),
      .cfg          (cfg),
      .step         (step),
      .ci_idx       (ci_idx),
      .co_idx       (co_idx),
      .node_idx     (node_idx),
      .job_finished (job_finished),
      .done         (done)
   );

   mm_addr_gen u_addr_gen (
      .clk               (clk),
      .rstn              (rstn),
      .cfg               (cfg),
      .step              (step),
      .ci_idx            (ci_idx),
      .co_idx            (co_idx),
      .node_idx          (node_idx),
      .input_addr        (input_addr),
      .input_addr_valid  (input_addr_valid),
      .weight_addr       (weight_addr),
      .weight_addr_valid (weight_addr_valid),
      .bias_addr         (bias_addr),
      .bias_addr_valid   (bias_addr_valid),
      .step_out          (step_ag)
   );

   mm_mac_array u_mac_array (
      .clk               (clk),
      .rstn              (rstn),
      .input_data        (input_data),
      .input_data_valid  (input_data_valid),
      .weight_data       (weight_data),
      .weight_data_valid (weight_data_valid),
      .step_in           (step_ag),
      .acc               (acc),
      .acc_valid         (acc_valid),
      .acc_last          (acc_last)
   );

   mm_post_proc u_post_proc (
      .clk               (clk),
      .rstn              (rstn),
      .cfg               (cfg),
      .bias_data         (bias_data),
      .bias_data_valid   (bias_data_valid),
      .acc               (acc),
      .acc_valid         (acc_valid),
      .acc_last          (acc_last),
      .output_addr       (output_addr),
      .output_data       (output_data),
      .output_data_valid (output_data_valid),
      .job_finished      (job_finished)
   );

endmodule

//--- tb/mm_tb.sv
`timescale 1ns/1ps

module mm_tb;
   import mm_cfg_pkg::*;
   import mm_data_pkg::*;

   localparam int JOB_BASE = 'h01;
   localparam int IN_BASE  = 'h10;
   localparam int W_BASE   = 'h20;
   localparam int B_BASE   = 'h30;
   localparam int EXP_BASE = 'h40;
   localparam int MAX_GAP  = 9;

   logic                   clk;
   logic                   rstn;
   logic                   start_valid;
   mm_job_t                job;
   logic [IN_ADDR_W-1:0]   input_addr;
   logic                   input_addr_valid;
   lane_vec_t              input_data;
   logic                   input_data_valid;
   logic [W_ADDR_W-1:0]    weight_addr;
   logic                   weight_addr_valid;
   weight_tile_t           weight_data;
   logic                   weight_data_valid;
   logic [BIAS_ADDR_W-1:0] bias_addr;
   logic                   bias_addr_valid;
   acc_vec_t               bias_data;
   logic                   bias_data_valid;
   logic [OUT_ADDR_W-1:0]  output_addr;
   acc_vec_t               output_data;
   logic                   output_data_valid;
   logic                   done;

   logic [255:0] vec [0:255];
   lane_vec_t    in_mem [0:(1<<IN_ADDR_W)-1];
   weight_tile_t w_mem [0:(1<<W_ADDR_W)-1];
   acc_vec_t     b_mem [0:(1<<BIAS_ADDR_W)-1];

   integer seed = 32'h047a_79ec;
   int     cyc = 0;
   int     start_cyc = 0;
   int     issued = 0;
   int     done_count = 0;
   int     done_due = -1;
   int     exp_ptr = 0;
   int     budget = 0;
   bit     job_active = 0;
   bit     cur_bias_en = 0;
   int     exp_in_q[$];
   int     exp_w_q[$];
   int     exp_b_q[$];
   int     out_addr_q[$];
   int     due_q[$];
   bit     exp_last_q[$];

   // read requests seen in the previous cycle
   logic                   in_req_v = 0;
   logic                   w_req_v = 0;
   logic                   b_req_v = 0;
   logic [IN_ADDR_W-1:0]   in_req_a;
   logic [W_ADDR_W-1:0]    w_req_a;
   logic [BIAS_ADDR_W-1:0] b_req_a;

   mm_top uut (.*);

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   task automatic stop_on_error(input string why);
      $display("*** TEST FAILED ***");
      $display("%s", why);
      $fatal(1, "stopped at %0t", $time);
   endtask

   function automatic mm_job_t unpack_job(input logic [127:0] rec);
      mm_job_t jb;
      jb.weight_start = W_ADDR_W'(rec[127:112]);
      jb.input_start  = IN_ADDR_W'(rec[111:96]);
      jb.bias_start   = BIAS_ADDR_W'(rec[95:80]);
      jb.output_start = OUT_ADDR_W'(rec[79:64]);
      jb.ci_count     = rec[63:56];
      jb.co_count     = rec[55:48];
      jb.node_count   = rec[47:32];
      jb.bias_en      = rec[1];
      jb.relu_en      = rec[0];
      return jb;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // one-cycle memories
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      in_req_v = input_addr_valid;
      in_req_a = input_addr;
      w_req_v  = weight_addr_valid;
      w_req_a  = weight_addr;
      b_req_v  = bias_addr_valid;
      b_req_a  = bias_addr;
   end

   always @(posedge clk) begin
      #1;
      input_data        = in_req_v ? in_mem[in_req_a] : '0;
      input_data_valid  = in_req_v;
      weight_data       = w_req_v ? w_mem[w_req_a] : '0;
      weight_data_valid = w_req_v;
      bias_data         = b_req_v ? b_mem[b_req_a] : '0;
      bias_data_valid   = b_req_v;
   end

   ////////////////////////////////////////////////////////////////////////////
   // response checker, sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      bit last_now;
      last_now = 0;
      assert (input_addr_valid === weight_addr_valid)
         else stop_on_error("input and weight reads were not issued together");
      if (input_addr_valid) begin
         assert (job_active && exp_in_q.size() > 0)
            else stop_on_error("read address issued with no pending job step");
         assert (cyc == start_cyc + 1 + issued)
            else stop_on_error($sformatf("mismatch address cycle: got %h expected %h",
                                         cyc, start_cyc + 1 + issued));
         assert (int'(input_addr) == exp_in_q[0])
            else stop_on_error($sformatf("mismatch input_addr: got %h expected %h",
                                         input_addr, exp_in_q[0]));
         assert (int'(weight_addr) == exp_w_q[0])
            else stop_on_error($sformatf("mismatch weight_addr: got %h expected %h",
                                         weight_addr, exp_w_q[0]));
         last_now = exp_last_q[0];
         if (last_now) due_q.push_back(cyc + MM_PIPE_LAT);
         void'(exp_in_q.pop_front());
         void'(exp_w_q.pop_front());
         void'(exp_last_q.pop_front());
         issued++;
      end
      if (bias_addr_valid) begin
         assert (last_now && exp_b_q.size() > 0)
            else stop_on_error("bias read issued outside a last-ci step");
         assert (int'(bias_addr) == exp_b_q[0])
            else stop_on_error($sformatf("mismatch bias_addr: got %h expected %h",
                                         bias_addr, exp_b_q[0]));
         void'(exp_b_q.pop_front());
      end else begin
         assert (!(last_now && cur_bias_en))
            else stop_on_error("bias read missing on a last-ci step");
      end
      if (output_data_valid) begin
         assert (due_q.size() > 0 && out_addr_q.size() > 0)
            else stop_on_error("output appeared with no finished accumulation");
         assert (cyc == due_q[0])
            else stop_on_error($sformatf("mismatch output cycle: got %h expected %h",
                                         cyc, due_q[0]));
         assert (int'(output_addr) == out_addr_q[0])
            else stop_on_error($sformatf("mismatch output_addr: got %h expected %h",
                                         output_addr, out_addr_q[0]));
         assert (output_data == vec[EXP_BASE+exp_ptr][127:0])
            else stop_on_error($sformatf("mismatch output_data: got %h expected %h",
                                         output_data, vec[EXP_BASE+exp_ptr][127:0]));
         void'(due_q.pop_front());
         void'(out_addr_q.pop_front());
         exp_ptr++;
         if (out_addr_q.size() == 0) done_due = cyc + 1;
      end
      if (done) begin
         assert (cyc == done_due)
            else stop_on_error($sformatf("mismatch done cycle: got %h expected %h",
                                         cyc, done_due));
         done_count++;
         done_due   = -1;
         job_active = 0;
      end
   end

   // watchdog
   initial begin
      wait (budget > 0);
      repeat (budget) @(posedge clk);
      stop_on_error("watchdog expired before the last job finished");
   end

   ////////////////////////////////////////////////////////////////////////////
   // job driver
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      mm_job_t jb;
      int      n_jobs;
      int      total;
      int      gap;
      int      sum;
      rstn        = 1'b0;
      start_valid = 1'b0;
      job         = '0;
      input_data  = '0;
      weight_data = '0;
      bias_data   = '0;
      input_data_valid  = 1'b0;
      weight_data_valid = 1'b0;
      bias_data_valid   = 1'b0;
      for (int a = 0; a < (1<<IN_ADDR_W); a++) in_mem[a] = {4{16'(a ^ 'hA5C3)}};
      for (int a = 0; a < (1<<W_ADDR_W); a++) w_mem[a] = {16{16'(a ^ 'h3C5A)}};
      for (int a = 0; a < (1<<BIAS_ADDR_W); a++) b_mem[a] = {4{32'(a ^ 'h0BAD_F00D)}};
      $readmemh("tb/mm_vectors.hex", vec);
      n_jobs = int'(vec[0][31:24]);
      assert (n_jobs > 0)
         else stop_on_error("vectors file holds no jobs");
      for (int i = 0; i < int'(vec[0][23:16]); i++) in_mem[i] = vec[IN_BASE+i][63:0];
      for (int i = 0; i < int'(vec[0][15:8]); i++) w_mem[i] = vec[W_BASE+i];
      for (int i = 0; i < int'(vec[0][7:0]); i++) b_mem[i] = vec[B_BASE+i][127:0];

      sum = 20;
      for (int j = 0; j < n_jobs; j++) begin
         jb  = unpack_job(vec[JOB_BASE+j][127:0]);
         sum += int'(jb.node_count) * int'(jb.co_count) * int'(jb.ci_count) + 20 + MAX_GAP;
      end
      budget = sum + 8;

      repeat (8) @(posedge clk);
      #1 rstn = 1'b1;

      for (int j = 0; j < n_jobs; j++) begin
         jb    = unpack_job(vec[JOB_BASE+j][127:0]);
         gap   = 2 + ($random(seed) & 7);
         total = int'(jb.node_count) * int'(jb.co_count) * int'(jb.ci_count);
         repeat (gap) @(posedge clk);
         for (int n = 0; n < int'(jb.node_count); n++) begin
            for (int c = 0; c < int'(jb.co_count); c++) begin
               for (int i = 0; i < int'(jb.ci_count); i++) begin
                  exp_in_q.push_back(int'(jb.input_start) + n * int'(jb.ci_count) + i);
                  exp_w_q.push_back(int'(jb.weight_start) + c * int'(jb.ci_count) + i);
                  exp_last_q.push_back(i == int'(jb.ci_count) - 1);
               end
               if (jb.bias_en) exp_b_q.push_back(int'(jb.bias_start) + c);
               out_addr_q.push_back(int'(jb.output_start) + out_addr_q.size());
            end
         end
         @(posedge clk);
         #1;
         start_valid = 1'b1;
         job         = jb;
         start_cyc   = cyc;
         issued      = 0;
         cur_bias_en = jb.bias_en;
         job_active  = 1;
         @(posedge clk);
         #1 start_valid = 1'b0;
         if (j == 0) begin
            // a second start while busy is dropped
            repeat (2) @(posedge clk);
            #1;
            start_valid = 1'b1;
            job         = '1;
            @(posedge clk);
            #1;
            start_valid = 1'b0;
            job         = '0;
         end
         wait (done_count == j + 1);
         @(posedge clk);
         assert (issued == total)
            else stop_on_error($sformatf("mismatch address count: got %h expected %h",
                                         issued, total));
         assert (exp_in_q.size() == 0 && exp_b_q.size() == 0 && out_addr_q.size() == 0)
            else stop_on_error("job ended with expected reads or outputs still pending");
      end

      repeat (6) @(posedge clk);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- tb/mm_vectors.hex
// word @00: [31:24] jobs, [23:16] input words, [15:8] weight tiles, [7:0] bias words
// jobs @01: wstart inst bstart ostart (16b each), ci co (8b), nodes (16b), flags (bit1 bias, bit0 relu)
// inputs @10, weight tiles @20, bias words @30, expected outputs @40 in arrival order
@00
03090803
@01
0000_0000_0000_0010_0202_0002_0000_0003
0004_0004_0002_0020_0101_0002_0000_0000
0005_0006_0002_0030_0301_0001_0000_0002
@10
0004_0003_0002_0001
0001_0002_0000_FFFF
0002_0000_FFFD_0005
0003_FFFE_0001_0000
FF9C_0064_FFF9_0007
0010_FFF8_0004_FFFE
0001_0001_0001_0001
0003_FFFF_0000_0002
FFFB_000A_FF38_012C
@20
0001000000000000_0000000100000000_0000000000010000_0000000000000001
FFFD000000000000_0000000000000002_00000000FFFF0000_0001000100010001
0000000000000001_0000000000010000_0000000100000000_0001000000000000
0000000200000000_0000000000000000_0000000000010001_000000000000FFFF
FFFF000000000000_0000000000000003_0001000100000000_00000000FFFF0001
0001000000000000_0000000100000000_0000000000010000_0000000000000001
0001000100010001_0001000100010001_0001000100010001_0001000100010001
0002000000000000_0000FFFF00000000_00000000FC180000_00000000000003E8
@30
00000005_00000000_FFFFFFF6_00000001
FFFFFFCE_00000064_00000000_FFFFFFFF
00000028_0000001E_00000014_0000000A
@40
00000006_00000001_00000000_00000004
00000000_00000066_00000002_00000004
00000000_00000000_00000000_00000008
00000000_00000061_00000001_00000001
00000064_00000015_00000000_0000000E
FFFFFFF0_FFFFFFFA_00000008_FFFFFFFA
00000023_00000019_00030D59_000493EF
